//--- logic/fp_defs.svh
// Float word format and integer conversion constants, included by the packages and RTL
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// Word layout: sign, biased exponent, stored fraction (hidden one)
`define FP_W 27
`define FP_EXP_W 8
`define FP_FRAC_W 18

// Exponent of 1.0
`define FP_BIAS 127

// Above this exponent the integer result saturates
`define FP_INT_EXP_MAX 141

// Fast inverse square root seed constant for this word format
`define RSQRT_MAGIC 49920718

// Word for 1.5, used by the Newton step
`define FP_THREE_HALVES 33423360

// Signed integer result
`define INT_W 16
`define INT_MAX 32767

`endif

//--- logic/fp_pkg.sv
// Type packages for the float datapath (fp_pkg) and the integer conversion (conv_pkg)
`include "fp_defs.svh"
`default_nettype none

package fp_pkg;

    // Whole float word {sign, exponent, fraction}
    typedef logic [`FP_W-1:0] fp_word_t;

    // Biased exponent field
    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    // Stored fraction, also used for 1.f mantissas truncated to the same width
    typedef logic [`FP_FRAC_W-1:0] fp_frac_t;

    // Adder sum: carry bit, aligned mantissa, guard room for the shifted operand
    typedef logic [2*`FP_FRAC_W:0] fp_sum_t;

endpackage

package conv_pkg;

    // Saturating signed integer output
    typedef logic signed [`INT_W-1:0] int_word_t;

    // Signed power-of-two offset applied to the exponent
    typedef logic signed [`FP_EXP_W-1:0] fp_scale_t;

endpackage

`default_nettype wire

//--- logic/fp_add_mid_if.sv
// Registered adder state passed from the alignment stage to the normalization stage
`timescale 1ns/1ps
`default_nettype none

interface fp_add_mid_if;

    // Aligned sum or difference of the mantissas
    fp_pkg::fp_sum_t  pre_sum;
    fp_pkg::fp_exp_t  larger_exp;

    // Zero exponent flags for the pass-through cases
    logic             a_zero;
    logic             b_zero;

    // Raw operands, returned as-is when the other one is zero
    fp_pkg::fp_word_t a_word;
    fp_pkg::fp_word_t b_word;

    // Sign of the larger operand
    logic             sum_sign;

    modport align (output pre_sum, larger_exp, a_zero, b_zero, a_word, b_word, sum_sign);
    modport norm  (input  pre_sum, larger_exp, a_zero, b_zero, a_word, b_word, sum_sign);

endinterface

`default_nettype wire

//--- logic/fp_mul.sv
// Combinational float multiplier, instantiated by the inverse square root pipeline
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module fp_mul (
    input  wire fp_pkg::fp_word_t a,
    input  wire fp_pkg::fp_word_t b,
    output fp_pkg::fp_word_t      prod
);

    fp_pkg::fp_exp_t         a_exp;
    fp_pkg::fp_exp_t         b_exp;
    fp_pkg::fp_frac_t        a_mant;
    fp_pkg::fp_frac_t        b_mant;
    logic [2*`FP_FRAC_W-1:0] mant_prod;
    logic [`FP_EXP_W:0]      exp_sum;
    logic [`FP_EXP_W:0]      exp_adj;
    logic                    prod_top;
    logic                    underflow;

    assign a_exp = a[`FP_W-2 -: `FP_EXP_W];
    assign b_exp = b[`FP_W-2 -: `FP_EXP_W];

    // Hidden one on top, lowest fraction bit dropped
    assign a_mant = {1'b1, a[`FP_FRAC_W-1:1]};
    assign b_mant = {1'b1, b[`FP_FRAC_W-1:1]};

    assign mant_prod = a_mant * b_mant;
    assign prod_top  = mant_prod[2*`FP_FRAC_W-1];

    // Exponent sum keeps the carry so underflow is visible
    assign exp_sum = {1'b0, a_exp} + {1'b0, b_exp};

    // Product in [2,4) takes one extra exponent step
    assign exp_adj = prod_top ? exp_sum - (`FP_EXP_W+1)'(`FP_BIAS - 1)
                              : exp_sum - (`FP_EXP_W+1)'(`FP_BIAS);

    assign underflow = exp_sum < (`FP_EXP_W+1)'(`FP_BIAS + 1);

    // Zero operand or tiny result flushes to zero
    assign prod = (underflow || a_exp == '0 || b_exp == '0) ? '0 :
                  prod_top ? {a[`FP_W-1] ^ b[`FP_W-1], exp_adj[`FP_EXP_W-1:0],
                              mant_prod[2*`FP_FRAC_W-2 -: `FP_FRAC_W]}
                           : {a[`FP_W-1] ^ b[`FP_W-1], exp_adj[`FP_EXP_W-1:0],
                              mant_prod[2*`FP_FRAC_W-3 -: `FP_FRAC_W]};

endmodule

`default_nettype wire

//--- logic/fp_add_align.sv
// Float adder first stage: operand alignment, add or subtract, mid-stage registers
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module fp_add_align (
    input  wire                   iCLK,
    input  wire                   rst_n,
    input  wire fp_pkg::fp_word_t a,
    input  wire fp_pkg::fp_word_t b,
    fp_add_mid_if.align           mid
);

    logic             a_sign;
    logic             b_sign;
    fp_pkg::fp_exp_t  a_exp;
    fp_pkg::fp_exp_t  b_exp;
    fp_pkg::fp_frac_t a_mant;
    fp_pkg::fp_frac_t b_mant;
    fp_pkg::fp_exp_t  a_diff;
    fp_pkg::fp_exp_t  b_diff;
    logic             a_larger;
    fp_pkg::fp_sum_t  a_shifted;
    fp_pkg::fp_sum_t  b_shifted;
    fp_pkg::fp_sum_t  pre_sum;

    assign a_sign = a[`FP_W-1];
    assign b_sign = b[`FP_W-1];
    assign a_exp  = a[`FP_W-2 -: `FP_EXP_W];
    assign b_exp  = b[`FP_W-2 -: `FP_EXP_W];
    assign a_mant = {1'b1, a[`FP_FRAC_W-1:1]};
    assign b_mant = {1'b1, b[`FP_FRAC_W-1:1]};

    // Exponent first, fraction breaks the tie
    assign a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_mant > b_mant));

    assign a_diff = b_exp - a_exp;
    assign b_diff = a_exp - b_exp;

    // Smaller mantissa moves right, gone entirely past 35 places
    assign a_shifted = a_larger ? {1'b0, a_mant, {`FP_FRAC_W{1'b0}}} :
                       (a_diff > 8'd35) ? '0 :
                       ({1'b0, a_mant, {`FP_FRAC_W{1'b0}}} >> a_diff);
    assign b_shifted = !a_larger ? {1'b0, b_mant, {`FP_FRAC_W{1'b0}}} :
                       (b_diff > 8'd35) ? '0 :
                       ({1'b0, b_mant, {`FP_FRAC_W{1'b0}}} >> b_diff);

    // Opposite signs subtract small from large, so the sum stays positive
    assign pre_sum = (a_sign == b_sign) ? a_shifted + b_shifted :
                     a_larger           ? a_shifted - b_shifted :
                                          b_shifted - a_shifted;

    always_ff @(posedge iCLK) begin
        if (!rst_n) begin
            mid.pre_sum    <= '0;
            mid.larger_exp <= '0;
            mid.a_zero     <= 1'b0;
            mid.b_zero     <= 1'b0;
            mid.a_word     <= '0;
            mid.b_word     <= '0;
            mid.sum_sign   <= 1'b0;
        end else begin
            mid.pre_sum    <= pre_sum;
            mid.larger_exp <= (b_exp > a_exp) ? b_exp : a_exp;
            mid.a_zero     <= (a_exp == '0);
            mid.b_zero     <= (b_exp == '0);
            mid.a_word     <= a;
            mid.b_word     <= b;
            mid.sum_sign   <= a_larger ? a_sign : b_sign;
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_add_norm.sv
// Float adder second stage: leading-one search, renormalization and output register
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module fp_add_norm (
    input  wire              iCLK,
    input  wire              rst_n,
    fp_add_mid_if.norm       mid,
    output fp_pkg::fp_word_t sum
);

    localparam int SUM_W = $bits(fp_pkg::fp_sum_t);
    localparam int BUF_W = SUM_W + `FP_FRAC_W - 1;

    logic [5:0]       lead_shift;
    logic [BUF_W-1:0] frac_buf;
    logic [BUF_W-1:0] norm_shift;
    logic [BUF_W-1:0] uflow_shift;
    fp_pkg::fp_frac_t sum_frac;
    fp_pkg::fp_exp_t  sum_exp;
    logic             underflow;

    // Distance of the leading one from the top, SUM_W when the sum is zero
    always_comb begin
        lead_shift = 6'(SUM_W);
        for (int i = 0; i < SUM_W; i++) begin
            if (mid.pre_sum[i]) begin
                lead_shift = 6'(SUM_W - 1 - i);
            end
        end
    end

    assign frac_buf = {mid.pre_sum, {(`FP_FRAC_W-1){1'b0}}};

    // One extra place drops the hidden bit
    assign norm_shift  = frac_buf << (lead_shift + 6'd1);
    assign uflow_shift = frac_buf << lead_shift;

    assign sum_frac = norm_shift[BUF_W-1 -: `FP_FRAC_W];

    // Carry position of the sum sits one exponent step above the larger operand
    assign sum_exp = mid.larger_exp - fp_pkg::fp_exp_t'(lead_shift) + 8'd1;

    // Top bit clear after the plain shift means no leading one was found
    assign underflow = !uflow_shift[BUF_W-1];

    always_ff @(posedge iCLK) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (mid.a_zero && mid.b_zero) begin
            sum <= '0;
        end else if (mid.a_zero) begin
            sum <= mid.b_word;
        end else if (mid.b_zero) begin
            sum <= mid.a_word;
        end else if (underflow) begin
            sum <= '0;
        end else if (mid.pre_sum == '0) begin
            // Exact cancellation
            sum <= '0;
        end else begin
            sum <= {mid.sum_sign, sum_exp, sum_frac};
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_inv_sqrt.sv
// Five-cycle magic-number inverse square root pipeline with one Newton step
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module fp_inv_sqrt (
    input  wire                   iCLK,
    input  wire                   rst_n,
    input  wire fp_pkg::fp_word_t a,
    output fp_pkg::fp_word_t      inv_sqrt
);

    // Stage 1, combinational on the input word
    fp_pkg::fp_word_t y_1;
    fp_pkg::fp_word_t ysq_1;
    fp_pkg::fp_word_t half_a_1;

    // Stage 2 registers and product
    fp_pkg::fp_word_t ysq_2;
    fp_pkg::fp_word_t half_a_2;
    fp_pkg::fp_word_t prod_2;

    // Stage 3 register feeding the adder
    fp_pkg::fp_word_t prod_3;
    fp_pkg::fp_word_t step_4;

    // Stage 5 register holding the Newton factor
    fp_pkg::fp_word_t step_5;

    // Initial estimate delayed to match the multiply and add path
    fp_pkg::fp_word_t y_dly [5];

    fp_add_mid_if add_mid ();

    // Seed estimate straight from the bit pattern
    assign y_1 = fp_pkg::fp_word_t'(`RSQRT_MAGIC) - (a >> 1);

    // Halving is one step down in the exponent
    assign half_a_1 = {a[`FP_W-1], a[`FP_W-2 -: `FP_EXP_W] - 8'd1, a[`FP_FRAC_W-1:0]};

    fp_mul u_mul_sq (.a(y_1), .b(y_1), .prod(ysq_1));

    fp_mul u_mul_half (.a(half_a_2), .b(ysq_2), .prod(prod_2));

    // 1.5 - (a/2)*y*y, subtraction done as a sign flip
    fp_add_align u_add_align (
        .iCLK (iCLK),
        .rst_n(rst_n),
        .a    ({~prod_3[`FP_W-1], prod_3[`FP_W-2:0]}),
        .b    (fp_pkg::fp_word_t'(`FP_THREE_HALVES)),
        .mid  (add_mid.align)
    );

    fp_add_norm u_add_norm (.iCLK(iCLK), .rst_n(rst_n), .mid(add_mid.norm), .sum(step_4));

    // Refined estimate, combinational on the stage 5 registers
    fp_mul u_mul_out (.a(y_dly[4]), .b(step_5), .prod(inv_sqrt));

    always_ff @(posedge iCLK) begin
        if (!rst_n) begin
            ysq_2    <= '0;
            half_a_2 <= '0;
            prod_3   <= '0;
            step_5   <= '0;
            y_dly    <= '{default: '0};
        end else begin
            ysq_2    <= ysq_1;
            half_a_2 <= half_a_1;
            prod_3   <= prod_2;
            step_5   <= step_4;
            y_dly[0] <= y_1;
            for (int i = 1; i < 5; i++) begin
                y_dly[i] <= y_dly[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_scale_to_int.sv
// Power-of-two exponent shift then saturating conversion to a signed 16-bit integer
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module fp_scale_to_int (
    input  wire fp_pkg::fp_word_t    f,
    input  wire conv_pkg::fp_scale_t scale,
    output conv_pkg::int_word_t      value
);

    logic                            sign;
    fp_pkg::fp_exp_t                 exp_s;
    fp_pkg::fp_exp_t                 shift;
    logic [`INT_W+`FP_FRAC_W-1:0]    shift_buf;
    logic [`INT_W-1:0]               mag;

    assign sign = f[`FP_W-1];

    // Scaling wraps in the 8-bit exponent field
    assign exp_s = f[`FP_W-2 -: `FP_EXP_W] + fp_pkg::fp_exp_t'(scale);
    assign shift = exp_s - fp_pkg::fp_exp_t'(`FP_BIAS);

    // 1.f with the hidden one just above the fraction, moved up by the unbiased exponent
    assign shift_buf = {{(`INT_W-1){1'b0}}, 1'b1, f[`FP_FRAC_W-1:0]} << shift;

    // Integer part only
    assign mag = shift_buf[`INT_W+`FP_FRAC_W-1 -: `INT_W];

    always_comb begin
        if (exp_s < fp_pkg::fp_exp_t'(`FP_BIAS)) begin
            // Magnitude below one
            value = '0;
        end else if (exp_s > fp_pkg::fp_exp_t'(`FP_INT_EXP_MAX)) begin
            value = sign ? -conv_pkg::int_word_t'(`INT_MAX) : conv_pkg::int_word_t'(`INT_MAX);
        end else begin
            value = sign ? -conv_pkg::int_word_t'(mag) : conv_pkg::int_word_t'(mag);
        end
    end

endmodule

`default_nettype wire

//--- logic/fp_rsqrt_top.sv
// Top level: inverse square root pipeline followed by the scaled integer output
`timescale 1ns/1ps
`default_nettype none

module fp_rsqrt_top (
    input  wire                      iCLK,
    input  wire                      rst_n,
    input  wire fp_pkg::fp_word_t    a,
    input  wire conv_pkg::fp_scale_t scale,
    output fp_pkg::fp_word_t         rsqrt_out,
    output conv_pkg::int_word_t      int_out
);

    // Five edges from input to rsqrt_out
    fp_inv_sqrt u_inv_sqrt (
        .iCLK    (iCLK),
        .rst_n   (rst_n),
        .a       (a),
        .inv_sqrt(rsqrt_out)
    );

    // Same cycle as rsqrt_out, scale applied as a level
    fp_scale_to_int u_to_int (
        .f    (rsqrt_out),
        .scale(scale),
        .value(int_out)
    );

endmodule

`default_nettype wire

//--- test/fp_rsqrt_assert.sv
// Concurrent assertions on the inverse square root top level, attached by bind
`timescale 1ns/1ps
`default_nettype none

module fp_rsqrt_assert (
    input wire        iCLK,
    input wire        rst_n,
    input wire [26:0] rsqrt_out,
    input wire [15:0] int_out
);

    // Multiplier flushes tiny results, so a zero exponent means a zero word
    property no_zero_exp_word;
        @(posedge iCLK) disable iff (!rst_n)
            (rsqrt_out[25:18] == 8'd0) |-> (rsqrt_out == 27'd0);
    endproperty

    // Saturation stops at -32767
    property no_most_negative;
        @(posedge iCLK) disable iff (!rst_n)
            int_out != 16'h8000;
    endproperty

    // Cleared pipeline on release of reset
    property zero_after_reset;
        @(posedge iCLK) $rose(rst_n) |-> (rsqrt_out == 27'd0);
    endproperty

    a_no_zero_exp_word: assert property (no_zero_exp_word)
        else $error("rsqrt_out has a zero exponent but a nonzero word");
    a_no_most_negative: assert property (no_most_negative)
        else $error("int_out reached 16'h8000");
    a_zero_after_reset: assert property (zero_after_reset)
        else $error("rsqrt_out not zero after reset release");

endmodule

bind fp_rsqrt_top fp_rsqrt_assert u_assert (
    .iCLK     (iCLK),
    .rst_n    (rst_n),
    .rsqrt_out(rsqrt_out),
    .int_out  (int_out)
);

`default_nettype wire

//--- test/tb_checker.sv
// Checker for the testbench: delays expected results five edges and compares them with the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire        iCLK,
    input  wire        exp_valid,
    input  wire [26:0] exp_rsqrt,
    input  wire [15:0] exp_int,
    input  wire [31:0] exp_test,
    input  wire        flush,
    input  wire [26:0] rsqrt_out,
    input  wire [15:0] int_out,
    output int         n_checks,
    output int         n_errors,
    output int         n_tests
);

    // Five-deep delay line matching the pipeline latency
    logic        line_valid [5];
    logic [26:0] line_rsqrt [5];
    logic [15:0] line_int   [5];
    logic [31:0] line_test  [5];

    int    cur_test;
    int    cur_checks;
    int    cur_errors;
    logic  flushed;
    logic  bad;

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset";
            1:       return "directed";
            2:       return "random";
            3:       return "small_exp";
            4:       return "scale_sweep";
            default: return "unknown";
        endcase
    endfunction

    task automatic close_test();
        if (cur_checks > 0) begin
            $display("Test %s done: %0d checks, %0d errors",
                     test_name(cur_test), cur_checks, cur_errors);
            n_tests = n_tests + 1;
        end
        cur_checks = 0;
        cur_errors = 0;
    endtask

    initial begin
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        cur_test   = 0;
        cur_checks = 0;
        cur_errors = 0;
        flushed    = 1'b0;
        for (int i = 0; i < 5; i++) begin
            line_valid[i] = 1'b0;
            line_rsqrt[i] = '0;
            line_int[i]   = '0;
            line_test[i]  = '0;
        end
    end

    // Outputs read here hold the values from the previous edge
    always @(posedge iCLK) begin
        if (line_valid[4]) begin
            if (int'(line_test[4]) != cur_test) begin
                close_test();
                cur_test = int'(line_test[4]);
            end
            bad = 1'b0;
            if (rsqrt_out !== line_rsqrt[4]) begin
                $display("Fail %s: rsqrt_out expected %h actual %h",
                         test_name(cur_test), line_rsqrt[4], rsqrt_out);
                bad = 1'b1;
            end
            if (int_out !== line_int[4]) begin
                $display("Fail %s: int_out expected %h actual %h",
                         test_name(cur_test), line_int[4], int_out);
                bad = 1'b1;
            end
            n_checks   = n_checks + 1;
            cur_checks = cur_checks + 1;
            if (bad) begin
                n_errors   = n_errors + 1;
                cur_errors = cur_errors + 1;
            end
        end
        if (flush && !flushed) begin
            close_test();
            flushed = 1'b1;
        end
        line_valid[0] <= exp_valid;
        line_rsqrt[0] <= exp_rsqrt;
        line_int[0]   <= exp_int;
        line_test[0]  <= exp_test;
        for (int i = 1; i < 5; i++) begin
            line_valid[i] <= line_valid[i-1];
            line_rsqrt[i] <= line_rsqrt[i-1];
            line_int[i]   <= line_int[i-1];
            line_test[i]  <= line_test[i-1];
        end
    end

endmodule

`default_nettype wire

//--- test/tb_top.sv
// Simulation top tb_top with the clock module, stimulus, reference model and watchdog for fp_rsqrt_top
`timescale 1ns/1ps
`include "fp_defs.svh"
`default_nettype none

module tb_clock #(parameter int PERIOD = 10) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end
endmodule

module tb_top;

    localparam int N_RESET    = 4;
    localparam int N_DIRECTED = 4;
    localparam int N_RANDOM   = 200;
    localparam int N_SMALL    = 6;
    localparam int N_GAP      = 5;
    localparam int N_SWEEP    = 2 * 29 * 6;
    localparam int N_DRAIN    = 11;
    localparam int TOTAL_VEC  = N_RESET + N_DIRECTED + N_RANDOM + N_SMALL + N_GAP
                                + N_SWEEP + N_DRAIN;

    logic                clk;
    logic                rst_n;
    fp_pkg::fp_word_t    a;
    conv_pkg::fp_scale_t scale;
    fp_pkg::fp_word_t    rsqrt_out;
    conv_pkg::int_word_t int_out;

    // Expected values for the word driven this cycle
    logic                exp_valid;
    logic [26:0]         exp_rsqrt;
    logic [15:0]         exp_int;
    logic [31:0]         exp_test;
    logic                flush;
    int                  n_checks;
    int                  n_errors;
    int                  n_tests;
    integer              seed;

    tb_clock #(.PERIOD(10)) u_clock (.clk(clk));

    fp_rsqrt_top uut (
        .iCLK     (clk),
        .rst_n    (rst_n),
        .a        (a),
        .scale    (scale),
        .rsqrt_out(rsqrt_out),
        .int_out  (int_out)
    );

    tb_checker chk (
        .iCLK     (clk),
        .exp_valid(exp_valid),
        .exp_rsqrt(exp_rsqrt),
        .exp_int  (exp_int),
        .exp_test (exp_test),
        .flush    (flush),
        .rsqrt_out(rsqrt_out),
        .int_out  (int_out),
        .n_checks (n_checks),
        .n_errors (n_errors),
        .n_tests  (n_tests)
    );

    // Multiplier model with the lowest fraction bit dropped and a one-place normalize
    function automatic logic [26:0] ref_mul(input logic [26:0] x, input logic [26:0] y);
        logic [7:0]  xe;
        logic [7:0]  ye;
        logic [35:0] p;
        logic [8:0]  es;
        xe = x[25:18];
        ye = y[25:18];
        p  = 36'({1'b1, x[17:1]}) * 36'({1'b1, y[17:1]});
        es = {1'b0, xe} + {1'b0, ye};
        if (xe == 8'd0 || ye == 8'd0 || es < 9'd128) begin
            return '0;
        end
        if (p[35]) begin
            return {x[26] ^ y[26], 8'(es - 9'd126), p[34:17]};
        end
        return {x[26] ^ y[26], 8'(es - 9'd127), p[33:16]};
    endfunction

    // Adder model that aligns, adds or subtracts and renormalizes
    function automatic logic [26:0] ref_add(input logic [26:0] x, input logic [26:0] y);
        logic [7:0]  xe;
        logic [7:0]  ye;
        logic [17:0] xm;
        logic [17:0] ym;
        logic        x_big;
        logic [7:0]  d;
        logic [36:0] xsh;
        logic [36:0] ysh;
        logic [36:0] s;
        logic [53:0] nbuf;
        int          lead;
        xe    = x[25:18];
        ye    = y[25:18];
        xm    = {1'b1, x[17:1]};
        ym    = {1'b1, y[17:1]};
        x_big = (xe > ye) || (xe == ye && xm > ym);
        xsh   = {1'b0, xm, 18'd0};
        ysh   = {1'b0, ym, 18'd0};
        if (x_big) begin
            d   = xe - ye;
            ysh = (d > 8'd35) ? 37'd0 : (ysh >> d);
        end else begin
            d   = ye - xe;
            xsh = (d > 8'd35) ? 37'd0 : (xsh >> d);
        end
        if (x[26] == y[26]) begin
            s = xsh + ysh;
        end else begin
            s = x_big ? xsh - ysh : ysh - xsh;
        end
        if (xe == 8'd0 && ye == 8'd0) begin
            return '0;
        end
        if (xe == 8'd0) begin
            return y;
        end
        if (ye == 8'd0) begin
            return x;
        end
        if (s == 37'd0) begin
            return '0;
        end
        lead = 0;
        for (int i = 0; i < 37; i++) begin
            if (s[i]) begin
                lead = 36 - i;
            end
        end
        nbuf = {s, 17'd0} << (lead + 1);
        return {x_big ? x[26] : y[26], (xe > ye ? xe : ye) - 8'(lead) + 8'd1, nbuf[53:36]};
    endfunction

    // Magic seed followed by one Newton step y * (1.5 - a/2 * y * y)
    function automatic logic [26:0] ref_rsqrt(input logic [26:0] x);
        logic [26:0] y;
        logic [26:0] ysq;
        logic [26:0] half_x;
        logic [26:0] p;
        logic [26:0] step;
        y      = 27'(`RSQRT_MAGIC) - (x >> 1);
        ysq    = ref_mul(y, y);
        half_x = {x[26], x[25:18] - 8'd1, x[17:0]};
        p      = ref_mul(half_x, ysq);
        step   = ref_add({~p[26], p[25:0]}, 27'(`FP_THREE_HALVES));
        return ref_mul(y, step);
    endfunction

    // Exponent offset then saturating conversion
    function automatic logic [15:0] ref_to_int(input logic [26:0] f, input logic [7:0] sc);
        logic [7:0]  e;
        logic [33:0] ibuf;
        logic [15:0] mag;
        e    = f[25:18] + sc;
        ibuf = {15'd0, 1'b1, f[17:0]} << (e - 8'd127);
        mag  = ibuf[33:18];
        if (e < 8'd127) begin
            return 16'd0;
        end
        if (e > 8'd141) begin
            return f[26] ? 16'h8001 : 16'h7fff;
        end
        return f[26] ? 16'd0 - mag : mag;
    endfunction

    // One vector per falling edge together with its expected pair
    task automatic drive(input logic [26:0] w, input logic [7:0] sc, input logic chk_it,
                         input int test, input logic in_reset);
        @(negedge clk);
        rst_n     = !in_reset;
        a         = w;
        scale     = sc;
        exp_valid = chk_it;
        exp_test  = 32'(test);
        exp_rsqrt = in_reset ? 27'd0 : ref_rsqrt(w);
        exp_int   = ref_to_int(exp_rsqrt, sc);
    endtask

    function automatic logic [26:0] random_word();
        logic [31:0] r;
        logic [7:0]  e;
        r = $random(seed);
        e = r[25:18];
        if (e == 8'd0) begin
            e = 8'd1;
        end
        if (e == 8'hff) begin
            e = 8'hfe;
        end
        return {1'b0, e, r[17:0]};
    endfunction

    initial begin
        logic [26:0] sweep_in [2];
        seed      = 32'h76b2c7a7;
        rst_n     = 1'b0;
        a         = '0;
        scale     = '0;
        exp_valid = 1'b0;
        exp_rsqrt = '0;
        exp_int   = '0;
        exp_test  = '0;
        flush     = 1'b0;
        sweep_in[0] = {1'b0, 8'd125, 18'd0};
        sweep_in[1] = {1'b1, 8'd128, 18'd0};

        // Words sampled in reset must come out as zero
        for (int i = 0; i < N_RESET; i++) begin
            drive(random_word(), 8'd0, 1'b1, 0, 1'b1);
        end

        drive({1'b0, 8'd127, 18'd0}, 8'd0, 1'b1, 1, 1'b0);
        drive({1'b0, 8'd129, 18'd0}, 8'd0, 1'b1, 1, 1'b0);
        drive({1'b0, 8'd125, 18'd0}, 8'd0, 1'b1, 1, 1'b0);
        drive({1'b0, 8'd128, 18'd0}, 8'd0, 1'b1, 1, 1'b0);

        // Back to back so five words are in flight
        for (int i = 0; i < N_RANDOM; i++) begin
            drive(random_word(), 8'd0, 1'b1, 2, 1'b0);
        end

        // Zero word and tiny exponents
        drive(27'd0, 8'd0, 1'b1, 3, 1'b0);
        drive({1'b0, 8'd1, 18'd0}, 8'd0, 1'b1, 3, 1'b0);
        drive({1'b0, 8'd1, 18'h3ffff}, 8'd0, 1'b1, 3, 1'b0);
        drive({1'b0, 8'd2, 18'h15555}, 8'd0, 1'b1, 3, 1'b0);
        drive({1'b0, 8'd0, 18'h2aaaa}, 8'd0, 1'b1, 3, 1'b0);
        drive({1'b0, 8'd3, 18'h00001}, 8'd0, 1'b1, 3, 1'b0);

        // Small-exponent words leave the pipeline before the scale moves
        for (int i = 0; i < N_GAP; i++) begin
            drive(27'd0, 8'd0, 1'b0, 3, 1'b0);
        end

        // Scale held six cycles and only the first word of each group checked
        for (int k = 0; k < 2; k++) begin
            for (int sc = -8; sc <= 20; sc++) begin
                for (int j = 0; j < 6; j++) begin
                    drive(sweep_in[k], 8'(sc), j == 0, 4, 1'b0);
                end
            end
        end

        for (int i = 0; i < N_DRAIN - 3; i++) begin
            drive(27'd0, 8'd0, 1'b0, 4, 1'b0);
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        @(negedge clk);

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        #((TOTAL_VEC + 20) * 10);
        $display("Timeout: the run did not finish in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/fp_pkg.sv
logic/fp_add_mid_if.sv
logic/fp_mul.sv
logic/fp_add_align.sv
logic/fp_add_norm.sv
logic/fp_inv_sqrt.sv
logic/fp_scale_to_int.sv
logic/fp_rsqrt_top.sv
test/fp_rsqrt_assert.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exits nonzero on failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
